/* verif/csc_patterns.txt */
# W addr data with_next_pixel | P sof in0 in1 in2 exp0 exp1 exp2 | I gap random_extra_max
# all fields hex, channel 0 first, coefficients 10-bit signed with 0x100 = 1.0
# identity matrix straight after reset
P 1 10 20 30 10 20 30
P 0 ff 00 80 ff 00 80
I 0 3
P 0 01 fe 7f 01 fe 7f
I 4 0
# rgb to ycbcr with offsets 0, 128, 128
W 0 04d 0
W 1 096 0
W 2 01d 0
W 3 3d5 0
W 4 3ab 0
W 5 080 0
W 6 080 0
W 7 395 0
W 8 3eb 0
W 9 000 0
W a 080 0
W b 080 0
I 0 3
P 1 ff ff ff ff 80 80
P 0 00 00 00 00 80 80
I 0 3
P 0 ff 00 00 4c 55 ff
P 0 00 ff 00 95 2b 15
I 0 3
P 0 00 00 ff 1c ff 6b
P 0 10 80 c8 66 b6 42
I 2 3
# saturation, row 0 large positive, row 1 negative, row 2 offset of -100
W 0 1ff 0
W 1 1ff 0
W 2 1ff 0
W 3 300 0
W 4 000 0
W 5 000 0
W 6 000 0
W 7 000 0
W 8 100 0
W 9 000 0
W a 000 0
W b 39c 0
P 1 80 40 c8 ff 00 64
P 0 01 00 32 65 00 00
# identity written mid-frame, the rest of this frame keeps the clamp set
W 0 100 0
W 1 000 0
W 2 000 0
W 3 000 0
W 4 100 0
W 5 000 0
W 6 000 0
W 7 000 0
W 8 100 0
W 9 000 0
W a 000 0
P 0 00 00 00 00 00 00
P 0 ff ff ff ff 00 9b
I 0 3
# offset write in the same cycle as the sof pixel
W b 005 1
P 1 10 20 30 10 20 35
P 0 ff 20 fe ff 20 ff
I 1 2
# back to back, new frame in the middle of the burst
W b 000 1
P 1 00 01 02 00 01 02
P 0 11 22 33 11 22 33
P 0 44 55 66 44 55 66
P 0 77 88 99 77 88 99
P 0 aa bb cc aa bb cc
P 0 dd ee ff dd ee ff
P 1 fe dc ba fe dc ba
P 0 98 76 54 98 76 54
I 0 3
P 0 32 10 0f 32 10 0f
I 0 3
# writes past the register map
W c 3ff 0
W d 123 0
W e 200 0
W f 0ff 0
I 1 2
W e 3ff 1
P 1 12 34 56 12 34 56
P 0 ff 80 00 ff 80 00
P 0 ab cd ef ab cd ef
I 0 3

/* filelist.f */
+incdir+hdl
hdl/csc_pkg.sv
hdl/csc_coef_bank.sv
hdl/csc_matrix.sv
hdl/csc_top.sv
verif/csc_asserts.sv
verif/csc_tb.sv

/* verif/csc_tb.sv */
// self-checking testbench that replays verif/csc_patterns.txt into csc_top and checks every output
`default_nettype none

`include "csc_params.svh"

module csc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import csc_pkg::*;

    localparam int    CLK_HALF      = 2;
    localparam int    RESET_CYCLES  = 10;
    localparam int    DRAIN_TIMEOUT = 200;
    localparam string PATTERN_FILE  = "verif/csc_patterns.txt";

    logic                   clk;
    logic                   rst_n;
    logic                   coef_we;
    bank_addr_t             coef_addr;
    logic [`CSC_COEF_W-1:0] coef_wdata;
    logic                   pix_valid;
    logic                   pix_sof;
    pixel_t                 pix_data;
    logic                   out_valid;
    logic                   out_sof;
    pixel_t                 out_data;

    // expected outputs with the oldest first
    pixel_t exp_pixel_q [$];
    logic   exp_sof_q   [$];
    int     exp_cycle_q [$];

    // write held back for the next pixel
    logic                   pend_we;
    bank_addr_t             pend_addr;
    logic [`CSC_COEF_W-1:0] pend_data;

    pixel_t mon_pixel;
    logic   mon_sof;
    int     mon_cycle;
    int     cycle_cnt = 0;
    int     pixels_sent = 0;
    int     pixels_checked = 0;
    integer seed;

    csc_top i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .coef_we    (coef_we),
        .coef_addr  (coef_addr),
        .coef_wdata (coef_wdata),
        .pix_valid  (pix_valid),
        .pix_sof    (pix_sof),
        .pix_data   (pix_data),
        .out_valid  (out_valid),
        .out_sof    (out_sof),
        .out_data   (out_data)
    );

    bind csc_top csc_asserts i_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .pix_valid (pix_valid),
        .out_valid (out_valid),
        .out_sof   (out_sof),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("** Error at %0t: %s is 0x%0h, expected 0x%0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            coef_we   = 1'b0;
            pix_valid = 1'b0;
            pix_sof   = 1'b0;
        end
    endtask

    task automatic drive_write(input bank_addr_t addr, input logic [`CSC_COEF_W-1:0] data);
        @(negedge clk);
        coef_we    = 1'b1;
        coef_addr  = addr;
        coef_wdata = data;
        pix_valid  = 1'b0;
        pix_sof    = 1'b0;
    endtask

    task automatic drive_pixel(input logic sof, input pixel_t pix, input pixel_t exp);
        @(negedge clk);
        // a held-back write goes out together with this pixel
        coef_we    = pend_we;
        coef_addr  = pend_addr;
        coef_wdata = pend_data;
        pend_we    = 1'b0;
        pix_valid  = 1'b1;
        pix_sof    = sof;
        pix_data   = pix;
        exp_pixel_q.push_back(exp);
        exp_sof_q.push_back(sof);
        exp_cycle_q.push_back(cycle_cnt);
        pixels_sent++;
    endtask

    // W addr data with_next | P sof in0 in1 in2 exp0 exp1 exp2 | I gap random_max
    task automatic run_patterns();
        int               fd;
        int               code;
        int               gap;
        logic [7:0]       kind;
        logic [31:0]      fld [7];
        logic [8*160-1:0] skip_line;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            fail_run({"could not open the pattern file ", PATTERN_FILE});
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", kind);
                if (code == 1) begin
                    case (kind)
                        "#": code = $fgets(skip_line, fd);
                        "W": begin
                            code = $fscanf(fd, "%h %h %h", fld[0], fld[1], fld[2]);
                            if (code != 3) begin
                                fail_run("malformed write record in the pattern file");
                            end else if (fld[2][0]) begin
                                pend_we   = 1'b1;
                                pend_addr = bank_addr_t'(fld[0]);
                                pend_data = fld[1][`CSC_COEF_W-1:0];
                            end else begin
                                drive_write(bank_addr_t'(fld[0]), fld[1][`CSC_COEF_W-1:0]);
                            end
                        end
                        "P": begin
                            code = $fscanf(fd, "%h %h %h %h %h %h %h", fld[0], fld[1],
                                           fld[2], fld[3], fld[4], fld[5], fld[6]);
                            if (code != 7) begin
                                fail_run("malformed pixel record in the pattern file");
                            end else begin
                                drive_pixel(fld[0][0],
                                            {fld[3][7:0], fld[2][7:0], fld[1][7:0]},
                                            {fld[6][7:0], fld[5][7:0], fld[4][7:0]});
                            end
                        end
                        "I": begin
                            code = $fscanf(fd, "%h %h", fld[0], fld[1]);
                            if (code != 2) begin
                                fail_run("malformed idle record in the pattern file");
                            end else begin
                                gap = fld[0];
                                // random extra gap only shifts timing
                                if (fld[1] != 0) begin
                                    gap += $unsigned($random(seed)) % (fld[1] + 1);
                                end
                                drive_idle(gap);
                            end
                        end
                        default: fail_run("unknown record type in the pattern file");
                    endcase
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_pixel_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
            drive_idle(1);
            waited++;
        end
        if (exp_pixel_q.size() != 0) begin
            fail_run("timed out waiting for the remaining output pixels");
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            if (out_valid === 1'b1) begin
                if (exp_pixel_q.size() == 0) begin
                    fail_run("an output pixel appeared with no input pixel in flight");
                end else begin
                    mon_pixel = exp_pixel_q.pop_front();
                    mon_sof   = exp_sof_q.pop_front();
                    mon_cycle = exp_cycle_q.pop_front();
                    check_value("out_data", 32'(out_data), 32'(mon_pixel));
                    check_value("out_sof", 32'(out_sof), 32'(mon_sof));
                    check_value("latency", 32'(cycle_cnt - mon_cycle), 32'(`CSC_LATENCY));
                    pixels_checked++;
                end
            end else begin
                check_value("out_valid", 32'(out_valid), 32'd0);
                check_value("out_sof while idle", 32'(out_sof), 32'd0);
            end
        end
    end

    // port assertion failures end the run as well
    always @(negedge clk) begin
        if (i_dut.i_asserts.fail_cnt != 0) begin
            fail_run("a concurrent assertion on the DUT ports failed");
        end
    end

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed       = 48688;
        rst_n      = 1'b0;
        coef_we    = 1'b0;
        coef_addr  = '0;
        coef_wdata = '0;
        pix_valid  = 1'b0;
        pix_sof    = 1'b0;
        pix_data   = '0;
        pend_we    = 1'b0;
        pend_addr  = '0;
        pend_data  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // quiet outputs straight after reset
        check_value("out_valid after reset", 32'(out_valid), 32'd0);
        check_value("out_sof after reset", 32'(out_sof), 32'd0);
        check_value("out_data after reset", 32'(out_data), 32'd0);
        run_patterns();
        wait_drain();
        drive_idle(2 * `CSC_LATENCY);
        if (pixels_checked == pixels_sent && pixels_sent > 0
                && i_dut.i_asserts.fail_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            fail_run($sformatf("%0d of %0d pixels checked, %0d assertion failures",
                               pixels_checked, pixels_sent, i_dut.i_asserts.fail_cnt));
        end
    end

endmodule

`default_nettype wire

/* verif/csc_asserts.sv */
// port-level concurrent assertions for the converter that are bound to csc_top
`default_nettype none

`include "csc_params.svh"

module csc_asserts (
    input logic            clk,
    input logic            rst_n,
    input logic            pix_valid,
    input logic            out_valid,
    input logic            out_sof,
    input csc_pkg::pixel_t out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed properties
    int fail_cnt = 0;

    // fixed pipeline depth without stalls
    property valid_latency_p;
        @(posedge clk) disable iff (!rst_n)
            out_valid == $past(pix_valid, `CSC_LATENCY);
    endproperty

    property sof_needs_valid_p;
        @(posedge clk) disable iff (!rst_n)
            out_sof |-> out_valid;
    endproperty

    property data_known_p;
        @(posedge clk) disable iff (!rst_n)
            out_valid |-> !$isunknown(out_data);
    endproperty

    assert property (valid_latency_p)
        else begin
            $error("out_valid does not follow pix_valid by %0d cycles", `CSC_LATENCY);
            fail_cnt++;
        end
    assert property (sof_needs_valid_p)
        else begin
            $error("out_sof high without out_valid");
            fail_cnt++;
        end
    assert property (data_known_p)
        else begin
            $error("out_data has X or Z bits while out_valid is high");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* hdl/csc_top.sv */
// converter top level joining the coefficient bank to the matrix pipeline
`default_nettype none

`include "csc_params.svh"

module csc_top (
    input  logic                   clk,
    input  logic                   rst_n,

    // software register writes
    input  logic                   coef_we,
    input  csc_pkg::bank_addr_t    coef_addr,
    input  logic [`CSC_COEF_W-1:0] coef_wdata,

    // pixel input stream
    input  logic                   pix_valid,
    input  logic                   pix_sof,
    input  csc_pkg::pixel_t        pix_data,

    // converted stream, no back-pressure
    output logic                   out_valid,
    output logic                   out_sof,
    output csc_pkg::pixel_t        out_data
);
    import csc_pkg::*;

    logic      frame_update;
    coef_set_t active_coefs;
    ofs_set_t  active_ofs;

    // first accepted pixel of a frame swaps in the shadow set
    assign frame_update = pix_valid & pix_sof;

    csc_coef_bank i_coef_bank (
        .clk          (clk),
        .rst_n        (rst_n),
        .coef_we      (coef_we),
        .coef_addr    (coef_addr),
        .coef_wdata   (coef_wdata),
        .frame_update (frame_update),
        .active_coefs (active_coefs),
        .active_ofs   (active_ofs)
    );

    csc_matrix i_matrix (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (pix_valid),
        .in_sof    (pix_sof),
        .in_pixel  (pix_data),
        .coefs     (active_coefs),
        .ofs       (active_ofs),
        .out_valid (out_valid),
        .out_sof   (out_sof),
        .out_pixel (out_data)
    );

endmodule

`default_nettype wire

/* hdl/csc_matrix.sv */
// five-stage 3x3 matrix, offset and clamp pipeline with valid and sof carried per stage
`default_nettype none

`include "csc_params.svh"

module csc_matrix (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               in_valid,
    input  logic               in_sof,
    input  csc_pkg::pixel_t    in_pixel,
    input  csc_pkg::coef_set_t coefs,
    input  csc_pkg::ofs_set_t  ofs,
    output logic               out_valid,
    output logic               out_sof,
    output csc_pkg::pixel_t    out_pixel
);
    import csc_pkg::*;

    // signed coef times zero-extended channel
    localparam int PROD_W = `CSC_COEF_W + `CSC_DATA_W + 1;
    // three products summed
    localparam int SUM_W = PROD_W + 2;
    // after the fraction shift, one spare bit for the offset add
    localparam int RES_W = SUM_W - `CSC_FRAC_BITS + 1;
    localparam int PIX_MAX = (1 << `CSC_DATA_W) - 1;

    // flags per stage
    logic valid_s1;
    logic valid_s2;
    logic valid_s3;
    logic valid_s4;
    logic sof_s1;
    logic sof_s2;
    logic sof_s3;
    logic sof_s4;

    // stage 1, pixel and the coefficient set it was accepted with
    pixel_t    pixel_s1;
    coef_set_t coefs_s1;
    ofs_set_t  ofs_s1;

    // stage 2, products
    logic signed [PROD_W-1:0] prod_d  [0:8];
    logic signed [PROD_W-1:0] prod_s2 [0:8];
    ofs_set_t                 ofs_s2;

    // stage 3, shifted and offset row sums
    logic signed [SUM_W-1:0] row_sum [0:2];
    logic signed [RES_W-1:0] res_d   [0:2];
    logic signed [RES_W-1:0] res_s3  [0:2];

    // stage 4, clamped channels
    pixel_t clamp_d;
    pixel_t clamp_s4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
            valid_s3 <= 1'b0;
            valid_s4 <= 1'b0;
            sof_s1   <= 1'b0;
            sof_s2   <= 1'b0;
            sof_s3   <= 1'b0;
            sof_s4   <= 1'b0;
        end else begin
            valid_s1 <= in_valid;
            valid_s2 <= valid_s1;
            valid_s3 <= valid_s2;
            valid_s4 <= valid_s3;
            // sof only counts on an accepted pixel
            sof_s1   <= in_valid & in_sof;
            sof_s2   <= sof_s1;
            sof_s3   <= sof_s2;
            sof_s4   <= sof_s3;
        end
    end

    always_comb begin
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < 3; c++) begin
                prod_d[r*3+c] = coefs_s1[r*3+c] * $signed({1'b0, pixel_s1[c]});
            end
        end
    end

    // arithmetic shift floors toward minus infinity
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            row_sum[r] = prod_s2[r*3] + prod_s2[r*3+1] + prod_s2[r*3+2];
            res_d[r]   = RES_W'(row_sum[r] >>> `CSC_FRAC_BITS) + RES_W'(ofs_s2[r]);
        end
    end

    // saturate to 0..255
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            if (res_s3[r] < 0) begin
                clamp_d[r] = '0;
            end else if (res_s3[r] > PIX_MAX) begin
                clamp_d[r] = '1;
            end else begin
                clamp_d[r] = res_s3[r][`CSC_DATA_W-1:0];
            end
        end
    end

    // datapath registers, qualified only by the flags above
    always_ff @(posedge clk) begin
        pixel_s1 <= in_pixel;
        coefs_s1 <= coefs;
        ofs_s1   <= ofs;
        prod_s2  <= prod_d;
        ofs_s2   <= ofs_s1;
        res_s3   <= res_d;
        clamp_s4 <= clamp_d;
    end

    // output holds its last pixel between valid beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_sof   <= 1'b0;
            out_pixel <= '0;
        end else begin
            out_valid <= valid_s4;
            out_sof   <= sof_s4;
            if (valid_s4) begin
                out_pixel <= clamp_s4;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/csc_coef_bank.sv */
// double-buffered coefficient bank, software writes land in shadow and go live at frame start
`default_nettype none

`include "csc_params.svh"

module csc_coef_bank (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   coef_we,
    input  csc_pkg::bank_addr_t    coef_addr,
    input  logic [`CSC_COEF_W-1:0] coef_wdata,
    input  logic                   frame_update,
    output csc_pkg::coef_set_t     active_coefs,
    output csc_pkg::ofs_set_t      active_ofs
);
    import csc_pkg::*;

    // 1.0 in coefficient fixed point
    localparam coef_t COEF_ONE = coef_t'(1 << `CSC_FRAC_BITS);

    coef_set_t shadow_coefs_q;
    coef_set_t shadow_coefs_d;
    coef_set_t active_coefs_q;
    ofs_set_t  shadow_ofs_q;
    ofs_set_t  shadow_ofs_d;
    ofs_set_t  active_ofs_q;

    // shadow set merged with this cycle's write
    always_comb begin
        shadow_coefs_d = shadow_coefs_q;
        shadow_ofs_d   = shadow_ofs_q;
        if (coef_we) begin
            if (coef_addr < `CSC_NUM_COEF) begin
                shadow_coefs_d[coef_addr] = coef_t'(coef_wdata);
            end else if (coef_addr < `CSC_NUM_REGS) begin
                shadow_ofs_d[coef_addr - `CSC_NUM_COEF] = ofs_t'(coef_wdata);
            end
            // addresses past the map fall through
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // identity matrix, zero offsets
            for (int i = 0; i < `CSC_NUM_COEF; i++) begin
                shadow_coefs_q[i] <= (i / 3 == i % 3) ? COEF_ONE : '0;
                active_coefs_q[i] <= (i / 3 == i % 3) ? COEF_ONE : '0;
            end
            for (int i = 0; i < 3; i++) begin
                shadow_ofs_q[i] <= '0;
                active_ofs_q[i] <= '0;
            end
        end else begin
            shadow_coefs_q <= shadow_coefs_d;
            shadow_ofs_q   <= shadow_ofs_d;
            if (frame_update) begin
                active_coefs_q <= shadow_coefs_d;
                active_ofs_q   <= shadow_ofs_d;
            end
        end
    end

    // the sof pixel itself already sees the new set
    always_comb begin
        if (frame_update) begin
            active_coefs = shadow_coefs_d;
            active_ofs   = shadow_ofs_d;
        end else begin
            active_coefs = active_coefs_q;
            active_ofs   = active_ofs_q;
        end
    end

endmodule

`default_nettype wire

/* hdl/csc_pkg.sv */
// shared pixel, coefficient, offset and bank-address types, imported by RTL and testbench
`default_nettype none

`include "csc_params.svh"

package csc_pkg;

    // three unsigned channels, channel 0 in the low byte
    typedef logic [2:0][`CSC_DATA_W-1:0] pixel_t;

    // signed fixed-point matrix coefficient
    typedef logic signed [`CSC_COEF_W-1:0] coef_t;

    // entry row*3+col weights input channel col for output channel row
    typedef coef_t coef_set_t [`CSC_NUM_COEF];

    // signed offset added after the fraction shift
    typedef logic signed [`CSC_OFS_W-1:0] ofs_t;

    typedef ofs_t ofs_set_t [3];

    // 0..8 coefficients, 9..11 offsets, 12..15 unused
    typedef logic [`CSC_ADDR_W-1:0] bank_addr_t;

endpackage

`default_nettype wire

/* hdl/csc_params.svh */
// width, fraction, latency and register-map macros for the colour-space converter
`ifndef CSC_PARAMS_SVH
`define CSC_PARAMS_SVH

// bits per colour channel
`define CSC_DATA_W     8

// signed coefficient width, 256 means 1.0
`define CSC_COEF_W     10
`define CSC_FRAC_BITS  8

// signed per-channel offset width
`define CSC_OFS_W      10

// cycles from an accepted pixel to its output
`define CSC_LATENCY    5

// coefficient bank map
`define CSC_NUM_COEF   9
`define CSC_NUM_REGS   12
`define CSC_ADDR_W     4

`endif
